//--- ahb_master_pkg.sv
// word-only write master; INCR of undefined length, BUSY, HSIZE and HWRITE are not supported
`default_nettype none

package ahb_master_pkg;

	localparam int ADDR_W = 32; // AHB address bus
	localparam int DATA_W = 32; // write data bus
	localparam int BEAT_W = 4;  // beat index, up to 16 beats

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BEAT_W-1:0] beat_cnt_t;
	typedef logic [BEAT_W:0]   beat_num_t; // beats in a burst, 1..16

	localparam addr_t WORD_BYTES = 32'd4; // address step per beat
	localparam data_t DATA_STEP  = 32'd4; // write data grows by this per beat

	// AHB HBURST codes, 001 (INCR) left out
	typedef enum logic [2:0] {
		HBURST_SINGLE = 3'b000,
		HBURST_WRAP4  = 3'b010,
		HBURST_INCR4  = 3'b011,
		HBURST_WRAP8  = 3'b100,
		HBURST_INCR8  = 3'b101,
		HBURST_WRAP16 = 3'b110,
		HBURST_INCR16 = 3'b111
	} hburst_t;

	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10, // first beat of a burst
		HTRANS_SEQ    = 2'b11  // remaining beats
	} htrans_t;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'b00,
		ST_NONSEQ = 2'b01,
		ST_SEQ    = 2'b10
	} fsm_state_t;

	// beat count of a burst type
	function automatic beat_num_t burst_beats(input hburst_t burst);
		beat_num_t beats;
		case (burst)
			HBURST_WRAP4, HBURST_INCR4:   beats = beat_num_t'(4);
			HBURST_WRAP8, HBURST_INCR8:   beats = beat_num_t'(8);
			HBURST_WRAP16, HBURST_INCR16: beats = beat_num_t'(16);
			default:                      beats = beat_num_t'(1); // single
		endcase
		return beats;
	endfunction

	function automatic logic burst_is_wrap(input hburst_t burst);
		return burst inside {HBURST_WRAP4, HBURST_WRAP8, HBURST_WRAP16};
	endfunction

endpackage

`default_nettype wire

//--- burst_ctrl_if.sv
// no clock inside; load and advance are one-cycle strobes, last is combinational from the counter
`default_nettype none

interface burst_ctrl_if import ahb_master_pkg::*; ();

	logic    load;    // command accepted this cycle
	logic    advance; // active address phase completes on this edge
	hburst_t burst;   // command burst type, only meaningful with load
	logic    last;    // current address phase is the final beat

	// owner of the strobes
	modport fsm (
		output load,
		output advance,
		output burst,
		input  last
	);

	modport counter (
		input  load,
		input  advance,
		input  burst,
		output last
	);

	modport addr (
		input load,
		input advance,
		input burst
	);

	// data side needs only the strobes
	modport wdata (
		input load,
		input advance
	);

endinterface

`default_nettype wire

//--- burst_fsm.sv
// one burst at a time; command fields must hold while cmd_valid is high and cmd_ready low
`default_nettype none

module burst_fsm import ahb_master_pkg::*; (
	input  logic      HCLK,
	input  logic      HRESET,
	input  logic      HREADY,
	input  logic      cmd_valid,
	output logic      cmd_ready,
	output htrans_t   HTRANS,
	input  hburst_t   cmd_burst,
	burst_ctrl_if.fsm ctrl
);

	fsm_state_t state;     // current transfer state
	fsm_state_t state_nxt;
	logic       accept;    // handshake this edge

	// idle and previous data phase done
	assign cmd_ready = (state == ST_IDLE) && HREADY;
	assign accept    = cmd_valid && cmd_ready;

	assign ctrl.load    = accept;    // same-edge pulse
	assign ctrl.burst   = cmd_burst; // sampled by others on load
	assign ctrl.advance = (state != ST_IDLE) && HREADY;

	always_comb begin
		state_nxt = state; // hold through wait states
		case (state)
			ST_IDLE: begin
				if (accept)
					state_nxt = ST_NONSEQ;
			end
			ST_NONSEQ, ST_SEQ: begin
				// last beat done means back to idle for at least a cycle
				if (ctrl.advance)
					state_nxt = ctrl.last ? ST_IDLE : ST_SEQ;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge HCLK) begin
		if (!HRESET)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	// transfer type straight from state
	always_comb begin
		case (state)
			ST_NONSEQ: HTRANS = HTRANS_NONSEQ;
			ST_SEQ:    HTRANS = HTRANS_SEQ;
			default:   HTRANS = HTRANS_IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- beat_counter.sv
// burst length fixed at load; load and advance never fall on the same edge
`default_nettype none

module beat_counter import ahb_master_pkg::*; (
	input  logic          HCLK,
	input  logic          HRESET,
	burst_ctrl_if.counter ctrl
);

	hburst_t   burst_q;  // burst type of the running command
	beat_cnt_t count_q;  // beats whose address phase completed
	beat_cnt_t last_idx; // index of the final beat

	always_ff @(posedge HCLK) begin
		if (!HRESET) begin
			burst_q <= HBURST_SINGLE;
			count_q <= '0;
		end else if (ctrl.load) begin
			burst_q <= ctrl.burst;
			count_q <= '0; // fresh burst starts at beat 0
		end else if (ctrl.advance) begin
			count_q <= count_q + beat_cnt_t'(1);
		end
	end

	// 16 beats gives index 15, fits the 4-bit counter
	assign last_idx = beat_cnt_t'(burst_beats(burst_q) - beat_num_t'(1));

	assign ctrl.last = (count_q == last_idx); // combinational, follows count

endmodule

`default_nettype wire

//--- addr_gen.sv
// start address is forced word aligned; INCR bursts must not cross a 1 KB boundary
`default_nettype none

module addr_gen import ahb_master_pkg::*; (
	input  logic       HCLK,
	input  logic       HRESET,
	input  addr_t      cmd_addr,
	output addr_t      HADDR,
	output hburst_t    HBURST,
	burst_ctrl_if.addr ctrl
);

	addr_t   haddr_q;    // address of the current address phase
	hburst_t burst_q;    // latched burst type
	addr_t   start_addr; // cmd_addr with byte offset dropped
	addr_t   incr_addr;
	addr_t   wrap_mask;  // low bits that move inside the wrap block
	addr_t   next_addr;

	assign start_addr = cmd_addr & ~(WORD_BYTES - addr_t'(1));
	assign incr_addr  = haddr_q + WORD_BYTES;

	// block is beats * 4 bytes, so 16, 32 or 64
	assign wrap_mask = addr_t'(burst_beats(burst_q)) * WORD_BYTES - addr_t'(1);

	always_comb begin
		if (burst_is_wrap(burst_q))
			next_addr = (haddr_q & ~wrap_mask) | (incr_addr & wrap_mask); // upper bits kept
		else
			next_addr = incr_addr;
	end

	always_ff @(posedge HCLK) begin
		if (!HRESET) begin
			haddr_q <= '0;
			burst_q <= HBURST_SINGLE;
		end else if (ctrl.load) begin
			haddr_q <= start_addr;
			burst_q <= ctrl.burst;
		end else if (ctrl.advance) begin
			haddr_q <= next_addr; // held during waits
		end
	end

	assign HADDR  = haddr_q;
	assign HBURST = burst_q;

endmodule

`default_nettype wire

//--- wdata_gen.sv
// beat k carries the first word + 4*k; HWDATA only valid in a data phase
`default_nettype none

module wdata_gen import ahb_master_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESET,
	input  data_t       cmd_data,
	output data_t       HWDATA,
	burst_ctrl_if.wdata ctrl
);

	data_t pending_q; // word for the beat now in its address phase

	always_ff @(posedge HCLK) begin
		if (ctrl.load)
			pending_q <= cmd_data;
		else if (ctrl.advance)
			pending_q <= pending_q + DATA_STEP;
	end

	// address phase done, its word goes out in the next cycle
	always_ff @(posedge HCLK) begin
		if (!HRESET)
			HWDATA <= '0;
		else if (ctrl.advance)
			HWDATA <= pending_q; // held while HREADY low
	end

endmodule

`default_nettype wire

//--- ahb_burst_master.sv
// write-only AHB master, always OKAY response assumed; single master, no arbitration
`default_nettype none

module ahb_burst_master import ahb_master_pkg::*; (
	input  logic    HCLK,
	input  logic    HRESET,    // sync, active low
	input  logic    HREADY,
	input  logic    cmd_valid,
	output logic    cmd_ready,
	input  addr_t   cmd_addr,
	input  hburst_t cmd_burst,
	input  data_t   cmd_data,
	output addr_t   HADDR,
	output htrans_t HTRANS,
	output hburst_t HBURST,
	output data_t   HWDATA
);

	burst_ctrl_if u_ctrl (); // load/advance/burst/last between blocks

	// transfer sequencing and command handshake
	burst_fsm u_fsm (
		.HCLK      (HCLK),
		.HRESET    (HRESET),
		.HREADY    (HREADY),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.HTRANS    (HTRANS),
		.cmd_burst (cmd_burst),
		.ctrl      (u_ctrl.fsm)
	);

	beat_counter u_cnt (
		.HCLK   (HCLK),
		.HRESET (HRESET),
		.ctrl   (u_ctrl.counter)
	);

	// address phase side
	addr_gen u_addr (
		.HCLK     (HCLK),
		.HRESET   (HRESET),
		.cmd_addr (cmd_addr),
		.HADDR    (HADDR),
		.HBURST   (HBURST),
		.ctrl     (u_ctrl.addr)
	);

	// data phase side, one beat behind
	wdata_gen u_wdata (
		.HCLK     (HCLK),
		.HRESET   (HRESET),
		.cmd_data (cmd_data),
		.HWDATA   (HWDATA),
		.ctrl     (u_ctrl.wdata)
	);

endmodule

`default_nettype wire

//--- ahb_burst_master_chk.sv
// protocol assertions on the top-level bus; FSM state comes in through the bind port list
`default_nettype none

module ahb_burst_master_chk import ahb_master_pkg::*; (
	input logic       HCLK,
	input logic       HRESET,
	input logic       HREADY,
	input logic       cmd_ready,
	input addr_t      HADDR,
	input htrans_t    HTRANS,
	input hburst_t    HBURST,
	input data_t      HWDATA,
	input fsm_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	addr_t wrap_span;  // wrap block size in bytes, 0 for incrementing
	addr_t block_base; // block of the running wrap burst

	always_comb begin
		case (HBURST)
			HBURST_WRAP4:  wrap_span = addr_t'(16);
			HBURST_WRAP8:  wrap_span = addr_t'(32);
			HBURST_WRAP16: wrap_span = addr_t'(64);
			default:       wrap_span = '0;
		endcase
	end

	always_ff @(posedge HCLK) begin
		if (!HRESET)
			block_base <= '0;
		else if (HTRANS == HTRANS_NONSEQ)
			block_base <= HADDR & ~(wrap_span - addr_t'(1)); // first beat fixes the block
	end

	a_idle_after_reset: assert property (@(posedge HCLK) $rose(HRESET) |-> HTRANS == HTRANS_IDLE)
		else $error("HTRANS not IDLE after reset release");

	// address phase frozen during a wait
	a_addr_hold: assert property (@(posedge HCLK) disable iff (!HRESET)
		(!HREADY && HTRANS != HTRANS_IDLE) |=> $stable(HADDR) && $stable(HTRANS) && $stable(HBURST))
		else $error("address phase moved while HREADY was low");

	a_wdata_hold: assert property (@(posedge HCLK) disable iff (!HRESET) !HREADY |=> $stable(HWDATA))
		else $error("HWDATA moved while HREADY was low");

	a_ready_idle: assert property (@(posedge HCLK) disable iff (!HRESET) cmd_ready |-> state == ST_IDLE)
		else $error("cmd_ready high outside ST_IDLE");

	a_wrap_block: assert property (@(posedge HCLK) disable iff (!HRESET)
		(HTRANS == HTRANS_SEQ && wrap_span != '0) |->
		((HADDR & ~(wrap_span - addr_t'(1))) == block_base))
		else $error("SEQ address %h left its wrap block", HADDR);

endmodule

bind ahb_burst_master ahb_burst_master_chk u_chk (
	.HCLK      (HCLK),
	.HRESET    (HRESET),
	.HREADY    (HREADY),
	.cmd_ready (cmd_ready),
	.HADDR     (HADDR),
	.HTRANS    (HTRANS),
	.HBURST    (HBURST),
	.HWDATA    (HWDATA),
	.state     (u_fsm.state)
);

`default_nettype wire

//--- tb_ahb_burst_master.sv
// run from the project root so burst_vectors.txt is found; commands are issued back to back
`default_nettype none

module tb_ahb_burst_master import ahb_master_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam string       VEC_FILE  = "burst_vectors.txt";
	localparam int          MAX_TESTS = 64;
	localparam logic [31:0] SEED      = 32'hfaf8_f832;

	logic    HCLK = 1'b0;
	logic    HRESET;
	logic    HREADY = 1'b1; // only the HREADY process drives this
	logic    cmd_valid;
	logic    cmd_ready;
	addr_t   cmd_addr;
	hburst_t cmd_burst;
	data_t   cmd_data;
	addr_t   HADDR;
	htrans_t HTRANS;
	hburst_t HBURST;
	data_t   HWDATA;

	addr_t   v_addr [MAX_TESTS]; // one entry per vector line
	hburst_t v_burst [MAX_TESTS];
	data_t   v_data [MAX_TESTS];
	int      v_wait [MAX_TESTS]; // percent of cycles with HREADY low
	int      n_tests = 0;
	int      bad_vectors = 0;

	logic    hready_rand = 1'b0; // toggle until the first command
	int      wait_pct = 0;

	int      errors = 0;      // written by the monitor only
	int      passes = 0;
	int      fails = 0;
	int      tests_done = 0;
	int      accepts = 0;
	int      post_reset = 0;
	int      next_test = 0;   // vector index for the next NONSEQ
	int      cur = 0;
	int      beat = 0;
	int      cur_beats = 0;
	int      err_start = 0;
	logic    in_burst = 1'b0;
	logic    idle_seen = 1'b1;
	logic    data_open = 1'b0; // a data phase is waiting for HREADY
	logic    data_ends_test = 1'b0;
	data_t   data_exp;

	always #5 HCLK = ~HCLK;

	ahb_burst_master u_dut (
		.HCLK      (HCLK),
		.HRESET    (HRESET),
		.HREADY    (HREADY),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_addr  (cmd_addr),
		.cmd_burst (cmd_burst),
		.cmd_data  (cmd_data),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HBURST    (HBURST),
		.HWDATA    (HWDATA)
	);

	// beats per burst code, straight from the AHB table
	function automatic int beats_of(input hburst_t b);
		case (b)
			HBURST_WRAP4, HBURST_INCR4: return 4;
			HBURST_WRAP8, HBURST_INCR8: return 8;
			HBURST_WRAP16, HBURST_INCR16: return 16;
			default: return 1;
		endcase
	endfunction

	// address of beat k, wrap keeps the offset modulo the block size
	function automatic addr_t model_addr(input addr_t start, input hburst_t b, input int k);
		addr_t base;
		addr_t span;
		addr_t block;
		base = {start[31:2], 2'b00};
		span = addr_t'(4 * beats_of(b));
		if (b == HBURST_WRAP4 || b == HBURST_WRAP8 || b == HBURST_WRAP16) begin
			block = base - (base % span);
			return block + ((base - block + addr_t'(4 * k)) % span);
		end
		return base + addr_t'(4 * k);
	endfunction

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_trans(input string what, input htrans_t exp, input htrans_t act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %s, got %s (%b)", $time, what,
				exp.name(), act.name(), act);
			errors++;
		end
	endtask

	task automatic check_burst(input string what, input hburst_t exp, input hburst_t act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %s, got %s (%b)", $time, what,
				exp.name(), act.name(), act);
			errors++;
		end
	endtask

	task automatic check_ready(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, what, exp, act);
			errors++;
		end
	endtask

	task automatic note_fault(input string msg);
		$display("at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// columns: start addr, burst code, first word, wait percent, beats, last addr
	task automatic load_vectors();
		int          fd;
		int          got;
		int          wp;
		int          nb;
		string       line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] last;
		logic [3:0]  b;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", VEC_FILE);
			bad_vectors++;
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			got = $sscanf(line, "%h %h %h %d %d %h", a, b, d, wp, nb, last);
			if (got == 6) begin // comment and blank lines parse short
				if (b == 4'd1 || b > 4'd7) begin
					$display("vector %0d: burst code %h is not supported", n_tests, b);
					bad_vectors++;
				end
				v_addr[n_tests] = a;
				v_burst[n_tests] = hburst_t'(b[2:0]);
				v_data[n_tests] = d;
				v_wait[n_tests] = wp;
				if (beats_of(v_burst[n_tests]) != nb ||
					model_addr(a, v_burst[n_tests], nb - 1) != last) begin
					$display("vector %0d: beat count or last address disagrees with the burst rules",
						n_tests);
					bad_vectors++;
				end
				n_tests++;
			end
		end
		$fclose(fd);
	endtask

	// one address phase completed on this edge
	task automatic take_beat();
		htrans_t trans_exp;
		trans_exp = in_burst ? HTRANS_SEQ : HTRANS_NONSEQ; // what the model expects next
		check_trans("HTRANS", trans_exp, HTRANS);
		if (HTRANS == HTRANS_NONSEQ) begin
			if (in_burst)
				note_fault($sformatf("test %0d cut off after %0d of %0d beats",
					cur, beat, cur_beats));
			if (!idle_seen)
				note_fault("new burst started without an IDLE transfer before it");
			if (next_test >= n_tests) begin
				note_fault("NONSEQ transfer with no command left to serve");
				return;
			end
			cur = next_test;
			next_test++;
			cur_beats = beats_of(v_burst[cur]);
			beat = 0;
			err_start = errors;
			in_burst = 1'b1;
			idle_seen = 1'b0;
		end else if (!in_burst) begin
			note_fault("SEQ transfer outside any burst, too many beats issued");
			return;
		end
		check_addr("HADDR", model_addr(v_addr[cur], v_burst[cur], beat), HADDR);
		check_burst("HBURST", v_burst[cur], HBURST);
		data_exp = v_data[cur] + data_t'(4 * beat); // shows up in the next data phase
		data_open = 1'b1;
		beat++;
		data_ends_test = (beat == cur_beats);
		if (data_ends_test)
			in_burst = 1'b0;
	endtask

	task automatic finish_test();
		hburst_t b;
		b = v_burst[cur];
		if (errors == err_start)
			passes++;
		else
			fails++;
		$display("test %0d: %s from %h, %0d beats, %0d%% waits: %s", cur, b.name(), v_addr[cur],
			cur_beats, v_wait[cur], (errors == err_start) ? "ok" : "FAILED");
		tests_done++;
	endtask

	// bus monitor, samples on every rising edge
	always @(posedge HCLK) begin
		if (!HRESET) begin
			post_reset = 0;
		end else if (post_reset < 4) begin
			check_trans("HTRANS", HTRANS_IDLE, HTRANS);
			check_data("HWDATA", '0, HWDATA);
			check_ready("cmd_ready", HREADY, cmd_ready); // follows HREADY while idle
			post_reset++;
			if (post_reset == 4)
				$display("reset: %s", (errors == 0) ? "ok" : "FAILED");
		end else begin
			if (cmd_valid && cmd_ready)
				accepts++;
			if (data_open && HREADY) begin // data phase ends on this edge
				check_data("HWDATA", data_exp, HWDATA);
				data_open = 1'b0;
				if (data_ends_test)
					finish_test();
			end
			if (HTRANS == HTRANS_IDLE)
				idle_seen = 1'b1;
			else if (HREADY)
				take_beat();
		end
	end

	always @(posedge HCLK) begin
		if (hready_rand)
			HREADY <= (int'($urandom_range(99)) >= wait_pct);
		else
			HREADY <= ~HREADY; // exercise cmd_ready right after reset
	end

	task automatic drive_commands();
		int i;
		repeat (8) @(posedge HCLK);
		HRESET <= 1'b1;
		repeat (4) @(posedge HCLK); // reset checks run here
		hready_rand <= 1'b1;
		for (i = 0; i < n_tests; i++) begin
			cmd_valid <= 1'b1;
			cmd_addr <= v_addr[i];
			cmd_burst <= v_burst[i];
			cmd_data <= v_data[i];
			wait_pct <= v_wait[i];
			@(posedge HCLK);
			while (!(cmd_valid && cmd_ready))
				@(posedge HCLK); // held until taken
		end
		cmd_valid <= 1'b0;
		wait (tests_done == n_tests);
		repeat (4) @(posedge HCLK); // let stray beats show up
	endtask

	task automatic end_run();
		if (accepts != n_tests)
			$display("%0d commands accepted for %0d vectors", accepts, n_tests);
		$display("tests %0d, passed %0d, failed %0d, errors %0d, bad vectors %0d",
			n_tests, passes, fails, errors, bad_vectors);
		if (errors == 0 && bad_vectors == 0 && accepts == n_tests && n_tests > 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	initial begin
		HRESET = 1'b0;
		cmd_valid = 1'b0;
		cmd_addr = '0;
		cmd_burst = HBURST_SINGLE;
		cmd_data = '0;
		void'($urandom(SEED));
		load_vectors();
		if (n_tests > 0)
			drive_commands();
		end_run();
	end

	// every test gets 16 beats at 8 cycles each
	initial begin
		wait (n_tests > 0);
		#(n_tests * 16 * 8 * 10 + 8 * 10 + 200);
		$display("watchdog: only %0d of %0d tests finished in time", tests_done, n_tests);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- burst_vectors.txt
# start_addr(hex) burst_code(hex) first_data(hex) hready_low_pct(dec) beats(dec) last_addr(hex)
# burst codes: 0 single, 2 wrap4, 3 incr4, 4 wrap8, 5 incr8, 6 wrap16, 7 incr16
00001000 0 11110000 0 1 00001000
00001004 3 22220000 0 4 00001010
00002000 5 33330000 0 8 0000201c
00003000 7 44440000 0 16 0000303c
00004008 2 55550000 0 4 00004004
00005014 4 66660000 0 8 00005010
00006038 6 77770000 0 16 00006034
0000700b 3 88880000 0 4 00007014
0000800e 2 99990000 0 4 00008008
10000000 0 a0000000 40 1 10000000
10000104 3 a1000000 30 4 10000110
10000200 5 a2000000 50 8 1000021c
100003c0 7 a3000000 25 16 100003fc
1000040c 2 a4000000 50 4 10000408
1000051c 4 a5000000 40 8 10000518
10000604 6 a6000000 60 16 10000600
fffffff0 6 ffffffff 35 16 ffffffec
00000800 7 00000001 20 16 0000083c
12345678 4 deadbeef 45 8 12345674
0000a000 0 0badf00d 70 1 0000a000

//--- filelist.f
ahb_master_pkg.sv
burst_ctrl_if.sv
burst_fsm.sv
beat_counter.sv
addr_gen.sv
wdata_gen.sv
ahb_burst_master.sv
ahb_burst_master_chk.sv
tb_ahb_burst_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ahb_burst_master -f filelist.f -o tb_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log

grep -q "sim failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "sim passed" sim.log && echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL, no pass message in sim.log"; exit 1; }
